//--- router_pkg.sv
// fixed 3x3 mesh only; tile ids are {column, row} nibbles in 1..3 with row 1 at the top
package router_pkg;

    localparam int mesh_cols = 3;
    localparam int mesh_rows = 3;

    // router port indices
    localparam int dir_north  = 0;
    localparam int dir_east   = 1;
    localparam int dir_south  = 2;
    localparam int dir_west   = 3;
    localparam int dir_local  = 4;
    localparam int port_count = 5;

    localparam int eject_depth = 8;

    // APB map, byte offsets
    localparam int apb_addr_w = 4;
    localparam logic [apb_addr_w-1:0] reg_inject = 4'h0;
    localparam logic [apb_addr_w-1:0] reg_eject  = 4'h4;
    localparam logic [apb_addr_w-1:0] reg_status = 4'h8;

    // column in [7:4], row in [3:0]
    typedef logic [7:0] t_tile_id;

    typedef logic [3:0] t_eject_count;

    // one APB data word, source id in the top byte
    typedef struct packed {
        t_tile_id    src;
        t_tile_id    dst;
        logic [15:0] payload;
    } t_tile_trans;

endpackage

//--- tile_router.sv
// column-then-row routing only; a word entering on north or south never turns east or west
module tile_router (
    input  logic                    clk,
    input  logic                    rst_n,
    input  router_pkg::t_tile_id    local_tile_id,
    input  logic                    in_north_req_valid,
    input  router_pkg::t_tile_trans in_north_req,
    output logic                    in_north_ready,
    output logic                    out_north_req_valid,
    output router_pkg::t_tile_trans out_north_req,
    input  logic                    out_north_ready,
    input  logic                    in_east_req_valid,
    input  router_pkg::t_tile_trans in_east_req,
    output logic                    in_east_ready,
    output logic                    out_east_req_valid,
    output router_pkg::t_tile_trans out_east_req,
    input  logic                    out_east_ready,
    input  logic                    in_south_req_valid,
    input  router_pkg::t_tile_trans in_south_req,
    output logic                    in_south_ready,
    output logic                    out_south_req_valid,
    output router_pkg::t_tile_trans out_south_req,
    input  logic                    out_south_ready,
    input  logic                    in_west_req_valid,
    input  router_pkg::t_tile_trans in_west_req,
    output logic                    in_west_ready,
    output logic                    out_west_req_valid,
    output router_pkg::t_tile_trans out_west_req,
    input  logic                    out_west_ready,
    input  logic                    in_local_req_valid,
    input  router_pkg::t_tile_trans in_local_req,
    output logic                    in_local_ready,
    output logic                    out_local_req_valid,
    output router_pkg::t_tile_trans out_local_req,
    input  logic                    out_local_ready
);
    import router_pkg::*;

    logic [port_count-1:0]        in_valid;
    logic [port_count-1:0]        in_rdy;
    t_tile_trans [port_count-1:0] in_word;
    logic [port_count-1:0] [2:0]  in_dir;
    logic [port_count-1:0]        out_valid;
    logic [port_count-1:0]        out_rdy;
    logic [port_count-1:0]        out_free;
    t_tile_trans [port_count-1:0] out_word;
    logic [port_count-1:0] [2:0]  rr_ptr;
    logic [port_count-1:0] [2:0]  gnt_idx;
    logic [port_count-1:0]        gnt_any;

    // east/west first, then north/south, then local
    function automatic logic [2:0] route_dir(t_tile_id dst, t_tile_id here);
        if (dst[7:4] > here[7:4]) return 3'(dir_east);
        if (dst[7:4] < here[7:4]) return 3'(dir_west);
        if (dst[3:0] > here[3:0]) return 3'(dir_south);
        if (dst[3:0] < here[3:0]) return 3'(dir_north);
        return 3'(dir_local);
    endfunction

    // turns XY routing can never take; pruning them keeps the ready paths loop free
    function automatic logic turn_ok(int src, int dst);
        if (src == dir_local) return 1'b1;
        if (src == dst) return 1'b0;
        if (src == dir_north || src == dir_south) begin
            return dst == dir_north || dst == dir_south || dst == dir_local;
        end
        return 1'b1;
    endfunction

    // port vectors, index 0 (north) in the low position
    assign in_valid = {in_local_req_valid, in_west_req_valid, in_south_req_valid,
                       in_east_req_valid, in_north_req_valid};
    assign in_word  = {in_local_req, in_west_req, in_south_req, in_east_req, in_north_req};
    assign out_rdy  = {out_local_ready, out_west_ready, out_south_ready,
                       out_east_ready, out_north_ready};

    assign {in_local_ready, in_west_ready, in_south_ready,
            in_east_ready, in_north_ready} = in_rdy;
    assign {out_local_req_valid, out_west_req_valid, out_south_req_valid,
            out_east_req_valid, out_north_req_valid} = out_valid;
    assign {out_local_req, out_west_req, out_south_req,
            out_east_req, out_north_req} = out_word;

    always_comb begin
        for (int i = 0; i < port_count; i++) begin
            in_dir[i] = route_dir(in_word[i].dst, local_tile_id);
        end
    end

    // register can take a word when empty or draining now
    assign out_free = ~out_valid | out_rdy;

    // rotating priority per output, search starts at rr_ptr
    always_comb begin
        in_rdy  = '0;
        gnt_any = '0;
        gnt_idx = '0;
        for (int o = 0; o < port_count; o++) begin
            for (int k = 0; k < port_count; k++) begin
                int i;
                i = int'(rr_ptr[o]) + k;
                if (i >= port_count) begin
                    i = i - port_count;
                end
                if (!gnt_any[o] && out_free[o] && in_valid[i] &&
                    in_dir[i] == 3'(o) && turn_ok(i, o)) begin
                    gnt_any[o] = 1'b1;
                    gnt_idx[o] = 3'(i);
                    in_rdy[i]  = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= '0;
            rr_ptr    <= '0;
        end else begin
            for (int o = 0; o < port_count; o++) begin
                if (gnt_any[o]) begin
                    out_valid[o] <= 1'b1;
                    // winner drops to lowest priority
                    rr_ptr[o] <= (gnt_idx[o] == 3'(port_count - 1)) ? 3'd0 : gnt_idx[o] + 3'd1;
                end else if (out_rdy[o]) begin
                    out_valid[o] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < port_count; o++) begin
            if (gnt_any[o]) begin
                out_word[o] <= in_word[gnt_idx[o]];
            end
        end
    end

endmodule

//--- fabric.sv
// 3x3 only; local port index of tile (col,row) is (col-1)*3 + (row-1), edge links idle
module fabric (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inj_valid,
    input  router_pkg::t_tile_trans       inj_trans,
    input  logic [8:0]                    inj_tile_sel,
    output logic [8:0]                    inj_ready,
    output logic [8:0]                    loc_valid,
    output router_pkg::t_tile_trans [8:0] loc_trans,
    input  logic [8:0]                    loc_ready
);
    import router_pkg::*;

    // links named by travel direction and indexed by the sending tile
    // the extra row or column of each array is the idle edge
    logic        s_valid [1:mesh_cols][0:mesh_rows];
    t_tile_trans s_req   [1:mesh_cols][0:mesh_rows];
    logic        s_ready [1:mesh_cols][0:mesh_rows];
    logic        n_valid [1:mesh_cols][1:mesh_rows+1];
    t_tile_trans n_req   [1:mesh_cols][1:mesh_rows+1];
    logic        n_ready [1:mesh_cols][1:mesh_rows+1];
    logic        e_valid [0:mesh_cols][1:mesh_rows];
    t_tile_trans e_req   [0:mesh_cols][1:mesh_rows];
    logic        e_ready [0:mesh_cols][1:mesh_rows];
    logic        w_valid [1:mesh_cols+1][1:mesh_rows];
    t_tile_trans w_req   [1:mesh_cols+1][1:mesh_rows];
    logic        w_ready [1:mesh_cols+1][1:mesh_rows];

    // top and bottom edges
    for (genvar col = 1; col <= mesh_cols; col++) begin : g_edge_col
        assign s_valid[col][0]           = 1'b0;
        assign s_req[col][0]             = '0;
        assign n_valid[col][mesh_rows+1] = 1'b0;
        assign n_req[col][mesh_rows+1]   = '0;
        assign s_ready[col][mesh_rows]   = 1'b1;
        assign n_ready[col][1]           = 1'b1;
    end

    // left and right edges
    for (genvar row = 1; row <= mesh_rows; row++) begin : g_edge_row
        assign e_valid[0][row]           = 1'b0;
        assign e_req[0][row]             = '0;
        assign w_valid[mesh_cols+1][row] = 1'b0;
        assign w_req[mesh_cols+1][row]   = '0;
        assign e_ready[mesh_cols][row]   = 1'b1;
        assign w_ready[1][row]           = 1'b1;
    end

    for (genvar col = 1; col <= mesh_cols; col++) begin : g_col
        for (genvar row = 1; row <= mesh_rows; row++) begin : g_row
            tile_router u_tile (
                .clk                 (clk),
                .rst_n               (rst_n),
                .local_tile_id       ({4'(col), 4'(row)}),
                .in_north_req_valid  (s_valid[col][row-1]),
                .in_north_req        (s_req[col][row-1]),
                .in_north_ready      (s_ready[col][row-1]),
                .out_north_req_valid (n_valid[col][row]),
                .out_north_req       (n_req[col][row]),
                .out_north_ready     (n_ready[col][row]),
                .in_east_req_valid   (w_valid[col+1][row]),
                .in_east_req         (w_req[col+1][row]),
                .in_east_ready       (w_ready[col+1][row]),
                .out_east_req_valid  (e_valid[col][row]),
                .out_east_req        (e_req[col][row]),
                .out_east_ready      (e_ready[col][row]),
                .in_south_req_valid  (n_valid[col][row+1]),
                .in_south_req        (n_req[col][row+1]),
                .in_south_ready      (n_ready[col][row+1]),
                .out_south_req_valid (s_valid[col][row]),
                .out_south_req       (s_req[col][row]),
                .out_south_ready     (s_ready[col][row]),
                .in_west_req_valid   (e_valid[col-1][row]),
                .in_west_req         (e_req[col-1][row]),
                .in_west_ready       (e_ready[col-1][row]),
                .out_west_req_valid  (w_valid[col][row]),
                .out_west_req        (w_req[col][row]),
                .out_west_ready      (w_ready[col][row]),
                // only the selected source tile sees the injector
                .in_local_req_valid  (inj_valid & inj_tile_sel[(col-1)*mesh_rows+row-1]),
                .in_local_req        (inj_trans),
                .in_local_ready      (inj_ready[(col-1)*mesh_rows+row-1]),
                .out_local_req_valid (loc_valid[(col-1)*mesh_rows+row-1]),
                .out_local_req       (loc_trans[(col-1)*mesh_rows+row-1]),
                .out_local_ready     (loc_ready[(col-1)*mesh_rows+row-1])
            );
        end
    end

endmodule

//--- mesh_injector.sv
// one pending injection; wrong-direction accesses and unknown offsets all answer pslverr
module mesh_injector (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [router_pkg::apb_addr_w-1:0]   paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                inj_valid,
    output router_pkg::t_tile_trans             inj_trans,
    output logic [8:0]                          inj_tile_sel,
    input  logic [8:0]                          inj_ready,
    input  router_pkg::t_tile_trans             head,
    input  router_pkg::t_eject_count            count,
    output logic                                pop
);
    import router_pkg::*;

    t_tile_trans wr_trans;
    logic        pending;
    logic        wr_take;

    function automatic logic id_ok(t_tile_id id);
        return id[7:4] >= 4'd1 && id[7:4] <= 4'(mesh_cols) &&
               id[3:0] >= 4'd1 && id[3:0] <= 4'(mesh_rows);
    endfunction

    // same index order as the fabric local ports
    function automatic logic [8:0] tile_onehot(t_tile_id id);
        return 9'd1 << ((int'(id[7:4]) - 1) * mesh_rows + int'(id[3:0]) - 1);
    endfunction

    assign wr_trans  = t_tile_trans'(pwdata);
    assign inj_valid = pending;

    always_comb begin
        pready  = 1'b1;
        pslverr = 1'b0;
        prdata  = '0;
        pop     = 1'b0;
        wr_take = 1'b0;
        if (psel && penable) begin
            if (pwrite) begin
                if (paddr == reg_inject && id_ok(wr_trans.src) && id_ok(wr_trans.dst)) begin
                    // stall until the previous word leaves
                    pready  = !pending;
                    wr_take = !pending;
                end else begin
                    pslverr = 1'b1;
                end
            end else begin
                case (paddr)
                    reg_eject: begin
                        if (count == '0) begin
                            pslverr = 1'b1;
                        end else begin
                            prdata = head;
                            pop    = 1'b1;
                        end
                    end
                    reg_status: prdata = {23'd0, pending, 4'd0, count};
                    default:    pslverr = 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (wr_take) begin
            pending <= 1'b1;
        end else if (|(inj_ready & inj_tile_sel)) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            inj_trans    <= wr_trans;
            inj_tile_sel <= tile_onehot(wr_trans.src);
        end
    end

endmodule

//--- mesh_ejector.sv
// 8-entry FIFO, one tile drained per cycle; pop must only be raised while count is nonzero
module mesh_ejector (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [8:0]                    loc_valid,
    input  router_pkg::t_tile_trans [8:0] loc_trans,
    output logic [8:0]                    loc_ready,
    input  logic                          pop,
    output router_pkg::t_tile_trans       head,
    output router_pkg::t_eject_count      count
);
    import router_pkg::*;

    t_tile_trans                      mem [eject_depth];
    logic [$clog2(eject_depth)-1:0]   wr_ptr;
    logic [$clog2(eject_depth)-1:0]   rd_ptr;
    logic [3:0]                       rr_ptr;
    logic [3:0]                       gnt_idx;
    logic                             gnt_any;
    logic                             can_push;

    // a slot frees up this cycle if software is reading
    assign can_push = (count != t_eject_count'(eject_depth)) || pop;
    assign head     = mem[rd_ptr];

    always_comb begin
        loc_ready = '0;
        gnt_any   = 1'b0;
        gnt_idx   = '0;
        for (int k = 0; k < mesh_cols * mesh_rows; k++) begin
            int i;
            i = int'(rr_ptr) + k;
            if (i >= mesh_cols * mesh_rows) begin
                i = i - mesh_cols * mesh_rows;
            end
            if (!gnt_any && can_push && loc_valid[i]) begin
                gnt_any      = 1'b1;
                gnt_idx      = 4'(i);
                loc_ready[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rr_ptr <= '0;
        end else begin
            if (gnt_any) begin
                wr_ptr <= wr_ptr + 1'b1;
                rr_ptr <= (gnt_idx == 4'(mesh_cols * mesh_rows - 1)) ? 4'd0 : gnt_idx + 4'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + t_eject_count'(gnt_any) - t_eject_count'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_any) begin
            mem[wr_ptr] <= loc_trans[gnt_idx];
        end
    end

endmodule

//--- mesh_top.sv
// APB slave for the 3x3 mesh; offsets 0x0 inject, 0x4 eject, 0x8 status
module mesh_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [router_pkg::apb_addr_w-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr
);
    import router_pkg::*;

    logic              inj_valid;
    t_tile_trans       inj_trans;
    logic [8:0]        inj_tile_sel;
    logic [8:0]        inj_ready;
    logic [8:0]        loc_valid;
    t_tile_trans [8:0] loc_trans;
    logic [8:0]        loc_ready;
    logic              pop;
    t_tile_trans       head;
    t_eject_count      count;

    mesh_injector u_injector (
        .clk          (clk),
        .rst_n        (rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .inj_valid    (inj_valid),
        .inj_trans    (inj_trans),
        .inj_tile_sel (inj_tile_sel),
        .inj_ready    (inj_ready),
        .head         (head),
        .count        (count),
        .pop          (pop)
    );

    fabric u_fabric (
        .clk          (clk),
        .rst_n        (rst_n),
        .inj_valid    (inj_valid),
        .inj_trans    (inj_trans),
        .inj_tile_sel (inj_tile_sel),
        .inj_ready    (inj_ready),
        .loc_valid    (loc_valid),
        .loc_trans    (loc_trans),
        .loc_ready    (loc_ready)
    );

    mesh_ejector u_ejector (
        .clk       (clk),
        .rst_n     (rst_n),
        .loc_valid (loc_valid),
        .loc_trans (loc_trans),
        .loc_ready (loc_ready),
        .pop       (pop),
        .head      (head),
        .count     (count)
    );

endmodule

//--- tb_mesh.sv
// reads mesh_stimulus.txt from the working directory, so run it from the project root
module tb_mesh;
    import router_pkg::*;

    localparam int half_period  = 4;
    localparam int sample_delay = 2;
    localparam int poll_limit   = 64;

    logic                  clk;
    logic                  rst_n;
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    integer      seed = 91;
    int          value_errors = 0;
    int          other_errors = 0;
    int          limit_cycles = 0;
    // words written and not yet read back
    t_tile_trans sent_q[$];

    mesh_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    task automatic check_trans(input string sig, input t_tile_trans exp,
                               input t_tile_trans act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h got %h", $time, sig, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_count(input string sig, input t_eject_count exp,
                               input t_eject_count act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %0d got %0d", $time, sig, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %b got %b", $time, sig, exp, act);
            value_errors++;
        end
    endtask

    // results sampled in the low phase before the completing edge
    task automatic apb_xfer(input logic wr, input logic [apb_addr_w-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        logic first_ready;
        @(negedge clk);
        paddr  = addr;
        pwrite = wr;
        pwdata = wdata;
        psel   = 1'b1;
        @(negedge clk);
        penable = 1'b1;
        #(sample_delay);
        first_ready = pready;
        while (!pready) begin
            @(negedge clk);
            #(sample_delay);
        end
        rdata = prdata;
        err   = pslverr;
        // reads and error responses finish in the first access cycle
        if (!wr || err) begin
            check_flag("pready", 1'b1, first_ready);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // with at_least set, any count from want upward ends the wait
    task automatic wait_count(input t_eject_count want, input logic at_least);
        logic [31:0] rdata;
        logic        err;
        logic        done;
        done = 1'b0;
        for (int n = 0; n < poll_limit && !done; n++) begin
            apb_xfer(1'b0, reg_status, '0, rdata, err);
            done = at_least ? (rdata[3:0] >= want) : (rdata[3:0] == want);
        end
        if (!done) begin
            $display("status count never reached %0d within %0d polls", want, poll_limit);
            other_errors++;
        end
    endtask

    task automatic eject_one(input logic any_order);
        logic [31:0] rdata;
        logic        err;
        t_tile_trans oldest;
        int          idx;
        wait_count(4'd1, 1'b1);
        apb_xfer(1'b0, reg_eject, '0, rdata, err);
        check_flag("pslverr", 1'b0, err);
        if (!any_order && sent_q.size() != 0) begin
            oldest = sent_q.pop_front();
            check_trans("eject prdata", oldest, t_tile_trans'(rdata));
        end else begin
            idx = -1;
            for (int i = 0; i < sent_q.size(); i++) begin
                if (idx < 0 && sent_q[i] == t_tile_trans'(rdata)) begin
                    idx = i;
                end
            end
            // a word seen twice no longer matches anything
            if (idx < 0) begin
                $display("eject read %h at %0t matches no outstanding word", rdata, $time);
                other_errors++;
            end else begin
                sent_q.delete(idx);
            end
        end
    endtask

    task automatic run_op(input string op, input logic [apb_addr_w-1:0] addr,
                          input logic [31:0] data, input logic flag);
        logic [31:0] rdata;
        logic        err;
        if (op == "W" || op == "Q" || op == "X") begin
            apb_xfer(1'b1, addr, data, rdata, err);
            check_flag("pslverr", flag, err);
            if (op != "W") begin
                sent_q.push_back(t_tile_trans'(data));
            end
            if (op == "X") begin
                wait_count(4'd1, 1'b0);
                eject_one(1'b0);
            end
        end else if (op == "R") begin
            apb_xfer(1'b0, addr, '0, rdata, err);
            check_flag("pslverr", flag, err);
            if (addr == reg_status) begin
                check_count("status count", t_eject_count'(data[3:0]),
                            t_eject_count'(rdata[3:0]));
                check_flag("status pending", data[8], rdata[8]);
            end else begin
                check_trans("prdata", t_tile_trans'(data), t_tile_trans'(rdata));
            end
        end else if (op == "P") begin
            wait_count(t_eject_count'(data[3:0]), 1'b0);
        end else if (op == "D" || op == "U") begin
            repeat (data) begin
                eject_one(op == "U");
            end
        end else begin
            $display("unknown stimulus operation %s", op);
            other_errors++;
        end
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d cycles", limit_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int                    fd;
        string                 op;
        string                 skip;
        logic [apb_addr_w-1:0] addr;
        logic [31:0]           data;
        logic                  flag;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        fd = $fopen("mesh_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open mesh_stimulus.txt");
            other_errors++;
        end else begin
            // 200 cycles for every line of the file
            while ($fgets(skip, fd) != 0) begin
                limit_cycles += 200;
            end
            $fclose(fd);
            fd = $fopen("mesh_stimulus.txt", "r");
            repeat (3) @(negedge clk);
            rst_n = 1'b1;
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    void'($fgets(skip, fd));
                end else if ($fscanf(fd, "%h %h %h", addr, data, flag) != 3) begin
                    $display("stimulus line for operation %s is incomplete", op);
                    other_errors++;
                    break;
                end else begin
                    run_op(op, addr, data, flag);
                    repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                end
            end
            $fclose(fd);
        end
        if (sent_q.size() != 0) begin
            $display("%0d written words never came back", sent_q.size());
            other_errors++;
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- mesh_stimulus.txt
# op addr data err, in hex: W write, Q write and expect it back, X write then read it back
# R read expecting data, P poll until status count = data, D/U read data words in/any order
R 8 00000000 0
R 4 00000000 1
X 0 11330001 0
X 0 33110002 0
X 0 21230003 0
X 0 32120004 0
X 0 13310005 0
X 0 22220006 0
X 0 12320007 0
X 0 23210008 0
X 0 31130009 0
Q 0 13310101 0
Q 0 13310102 0
Q 0 13310103 0
Q 0 13310104 0
D 0 00000004 0
Q 0 11220201 0
Q 0 12220202 0
Q 0 13220203 0
Q 0 21220204 0
Q 0 22220205 0
Q 0 23220206 0
Q 0 31220207 0
Q 0 32220208 0
Q 0 33220209 0
P 8 00000008 0
U 4 00000009 0
W 0 01220300 1
W 0 11400301 1
W 0 11300302 1
R 8 00000000 0
Q 0 11330401 0
Q 0 12230402 0
Q 0 13110403 0
Q 0 21320404 0
Q 0 23120405 0
Q 0 31130406 0
Q 0 32210407 0
Q 0 33210408 0
Q 0 11220409 0
Q 0 13330410 0
Q 0 31110411 0
Q 0 33130412 0
P 8 00000008 0
U 4 0000000c 0

//--- sim.f
router_pkg.sv
tile_router.sv
fabric.sv
mesh_injector.sv
mesh_ejector.sv
mesh_top.sv
tb_mesh.sv

//--- Makefile
TOP := tb_mesh

all: run

obj_dir/V$(TOP): sim.f $(wildcard *.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f

run: obj_dir/V$(TOP) mesh_stimulus.txt
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "PASS: all tests" sim.log

lint:
	verilator --lint-only --timing --top-module mesh_top -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
